// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mips_core
FILELIST  := project.f
OBJDIR    := obj_dir
SIM_BIN   := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := logic/mips_consts.svh dv/tb_ref_model.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

`include "mips_consts.svh"

mips_pkg::word_t model_regs [`REG_COUNT];

function automatic void model_reset();
    for (int i = 0; i < `REG_COUNT; i++) begin
        model_regs[i] = '0;
    end
endfunction

function automatic mips_pkg::inst_t enc_r(input logic [5:0] funct, input mips_pkg::reg_addr_t rd,
                                          input mips_pkg::reg_addr_t rs,
                                          input mips_pkg::reg_addr_t rt, input logic [4:0] sa);
    return {`OP_SPECIAL, rs, rt, rd, sa, funct};
endfunction

function automatic mips_pkg::inst_t enc_i(input logic [5:0] op, input mips_pkg::reg_addr_t rt,
                                          input mips_pkg::reg_addr_t rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// executes one instruction in program order and gives the write it makes
function automatic void model_step(input mips_pkg::inst_t inst, output logic we,
                                   output mips_pkg::reg_addr_t dst,
                                   output mips_pkg::word_t res);
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    mips_pkg::word_t sx;
    mips_pkg::word_t zx;
    logic [4:0]      sa;
    a   = model_regs[inst[`RS_HI:`RS_LO]];
    b   = model_regs[inst[`RT_HI:`RT_LO]];
    sx  = {{16{inst[`IMM_HI]}}, inst[`IMM_HI:`IMM_LO]};
    zx  = {16'h0000, inst[`IMM_HI:`IMM_LO]};
    sa  = inst[`SHAMT_HI:`SHAMT_LO];
    we  = 1'b1;
    res = '0;
    dst = inst[`RT_HI:`RT_LO];
    if (inst[`OPCODE_HI:`OPCODE_LO] == `OP_SPECIAL) begin
        dst = inst[`RD_HI:`RD_LO];
        case (inst[`FUNCT_HI:`FUNCT_LO])
            `FUNCT_SLL:  res = b << sa;
            `FUNCT_SRL:  res = b >> sa;
            `FUNCT_SRA:  res = $signed(b) >>> sa;
            `FUNCT_SLLV: res = b << a[4:0];
            `FUNCT_SRLV: res = b >> a[4:0];
            `FUNCT_SRAV: res = $signed(b) >>> a[4:0];
            `FUNCT_ADD, `FUNCT_ADDU: res = a + b;   // no trap
            `FUNCT_SUB, `FUNCT_SUBU: res = a - b;
            `FUNCT_AND:  res = a & b;
            `FUNCT_OR:   res = a | b;
            `FUNCT_XOR:  res = a ^ b;
            `FUNCT_NOR:  res = ~(a | b);
            `FUNCT_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `FUNCT_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            `FUNCT_MOVN: begin
                res = a;
                we  = (b != '0);
            end
            `FUNCT_MOVZ: begin
                res = a;
                we  = (b == '0);
            end
            default:     we = 1'b0;
        endcase
    end else begin
        case (inst[`OPCODE_HI:`OPCODE_LO])
            `OP_ANDI:  res = a & zx;
            `OP_ORI:   res = a | zx;
            `OP_XORI:  res = a ^ zx;
            `OP_LUI:   res = {inst[`IMM_HI:`IMM_LO], 16'h0000};
            `OP_ADDI, `OP_ADDIU: res = a + sx;
            `OP_SLTI:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            `OP_SLTIU: res = (a < sx) ? 32'd1 : 32'd0;
            default:   we = 1'b0;
        endcase
    end
    if (dst == '0) begin
        we = 1'b0;
    end
    if (we) begin
        model_regs[dst] = res;
    end
endfunction

`endif

// ==== dv/tb_mips_core.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module tb_mips_core;

    localparam int CLK_PERIOD = 4;
    localparam int RAND_COUNT = 400;
    localparam int TOTAL_INST = 100 + RAND_COUNT;  // directed plus random

    logic                clk;
    logic                rst_n_i;
    mips_pkg::inst_t     inst_i;
    logic                wb_we_o;
    mips_pkg::reg_addr_t wb_addr_o;
    mips_pkg::word_t     wb_data_o;

    // expected writes in drive order, each with the edge count it is due at
    logic                q_we [$];
    mips_pkg::reg_addr_t q_addr [$];
    mips_pkg::word_t     q_data [$];
    int                  q_due [$];

    int                  cyc = 0;
    logic                started = 1'b0;
    logic                exp_valid = 1'b0;
    logic                exp_we = 1'b0;
    mips_pkg::reg_addr_t exp_addr = '0;
    mips_pkg::word_t     exp_data = '0;
    int                  fail_count = 0;
    int                  fail_base = 0;
    int                  test_count = 0;
    integer              seed = 95751;
    logic [5:0]          r_functs [18];
    logic [5:0]          i_ops [8];

    `include "tb_ref_model.svh"

    mips_core uut (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .inst_i    (inst_i),
        .wb_we_o   (wb_we_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TOTAL_INST + 100) * CLK_PERIOD);
        $display("timeout after %0d ns, the pipeline stopped making progress", $time);
        $display("Verification failed");
        $finish;
    end

    // the entry popped here is compared at the next edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if ((q_due.size() != 0) && (q_due[0] == cyc + 1)) begin
            exp_valid <= 1'b1;
            exp_we    <= q_we.pop_front();
            exp_addr  <= q_addr.pop_front();
            exp_data  <= q_data.pop_front();
            void'(q_due.pop_front());
        end else begin
            exp_valid <= 1'b0;
        end
    end

    we_check: assert property (@(posedge clk) !started || !exp_valid || (wb_we_o == exp_we))
        else begin
            fail_count++;
            $display("[FAIL] %0t ns: wb_we_o is %0b, expected %0b", $time,
                     $sampled(wb_we_o), $sampled(exp_we));
        end

    data_check: assert property (@(posedge clk) !started || !exp_valid || !exp_we || !wb_we_o ||
                                 ((wb_addr_o == exp_addr) && (wb_data_o == exp_data)))
        else begin
            fail_count++;
            $display("[FAIL] %0t ns: write r%0d = %h, expected r%0d = %h", $time,
                     $sampled(wb_addr_o), $sampled(wb_data_o), $sampled(exp_addr),
                     $sampled(exp_data));
        end

    stray_check: assert property (@(posedge clk) !started || exp_valid || !wb_we_o)
        else begin
            fail_count++;
            $display("unexpected write to r%0d at %0t ns while no expected entry was due",
                     $sampled(wb_addr_o), $time);
        end

    task automatic drive(input mips_pkg::inst_t inst);
        logic                we;
        mips_pkg::reg_addr_t dst;
        mips_pkg::word_t     res;
        @(negedge clk);
        inst_i = inst;
        model_step(inst, we, dst, res);
        q_we.push_back(we);
        q_addr.push_back(dst);
        q_data.push_back(res);
        q_due.push_back(cyc + 4);   // seen on the outputs after the fourth edge
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        inst_i = '0;
        while (q_due.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        test_count++;
        if (fail_count == fail_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, fail_count - fail_base);
        end
        fail_base = fail_count;
    endtask

    task automatic check_reset();
        for (int r = 0; r < `REG_COUNT; r++) begin
            drive(enc_i(`OP_ORI, 5'(r), 5'(r), 16'ha500 + 16'(r)));  // reads its own target
        end
        finish_test("reset");
    endtask

    task automatic check_logic();
        drive(enc_i(`OP_LUI, 5'd1, 5'd0, 16'hf0f0));
        drive(enc_i(`OP_ORI, 5'd1, 5'd1, 16'h5a5a));
        drive(enc_i(`OP_LUI, 5'd2, 5'd0, 16'h0ff0));
        drive(enc_i(`OP_ORI, 5'd2, 5'd2, 16'hc3a5));
        drive(enc_r(`FUNCT_AND, 5'd3, 5'd1, 5'd2, 5'd0));
        drive(enc_r(`FUNCT_OR, 5'd4, 5'd1, 5'd2, 5'd0));
        drive(enc_r(`FUNCT_XOR, 5'd5, 5'd1, 5'd2, 5'd0));
        drive(enc_r(`FUNCT_NOR, 5'd6, 5'd1, 5'd2, 5'd0));
        drive(enc_i(`OP_ANDI, 5'd7, 5'd1, 16'hffff));
        drive(enc_i(`OP_ORI, 5'd8, 5'd2, 16'h8001));
        drive(enc_i(`OP_XORI, 5'd9, 5'd1, 16'h8000));
        drive(enc_i(`OP_LUI, 5'd10, 5'd0, 16'h8001));
        finish_test("logic");
    endtask

    task automatic check_shifts();
        drive(enc_i(`OP_LUI, 5'd1, 5'd0, 16'h8000));
        drive(enc_i(`OP_ORI, 5'd1, 5'd1, 16'h00f1));
        drive(enc_i(`OP_ORI, 5'd2, 5'd0, 16'h0024));   // low five bits give 4
        drive(enc_r(`FUNCT_SLL, 5'd3, 5'd0, 5'd1, 5'd4));
        drive(enc_r(`FUNCT_SRL, 5'd4, 5'd0, 5'd1, 5'd31));
        drive(enc_r(`FUNCT_SRA, 5'd5, 5'd0, 5'd1, 5'd7));
        drive(enc_r(`FUNCT_SLLV, 5'd6, 5'd2, 5'd1, 5'd0));
        drive(enc_r(`FUNCT_SRLV, 5'd7, 5'd2, 5'd1, 5'd0));
        drive(enc_r(`FUNCT_SRAV, 5'd8, 5'd2, 5'd1, 5'd0));
        finish_test("shifts");
    endtask

    task automatic check_arith();
        drive(enc_i(`OP_LUI, 5'd1, 5'd0, 16'h7fff));
        drive(enc_i(`OP_ORI, 5'd1, 5'd1, 16'hffff));
        drive(enc_i(`OP_ADDI, 5'd2, 5'd0, 16'hffff));
        drive(enc_i(`OP_ADDI, 5'd3, 5'd0, 16'h0001));
        drive(enc_r(`FUNCT_ADD, 5'd4, 5'd1, 5'd3, 5'd0));  // wraps
        drive(enc_r(`FUNCT_ADDU, 5'd5, 5'd2, 5'd3, 5'd0));
        drive(enc_i(`OP_ADDI, 5'd6, 5'd1, 16'h0001));
        drive(enc_i(`OP_ADDIU, 5'd7, 5'd3, 16'h8000));
        drive(enc_r(`FUNCT_SUB, 5'd8, 5'd3, 5'd2, 5'd0));
        drive(enc_r(`FUNCT_SUBU, 5'd9, 5'd0, 5'd3, 5'd0));
        drive(enc_r(`FUNCT_SLT, 5'd10, 5'd2, 5'd3, 5'd0));
        drive(enc_r(`FUNCT_SLTU, 5'd11, 5'd2, 5'd3, 5'd0));
        drive(enc_i(`OP_SLTI, 5'd12, 5'd2, 16'h0001));
        drive(enc_i(`OP_SLTIU, 5'd13, 5'd2, 16'h0001));
        drive(enc_i(`OP_SLTIU, 5'd14, 5'd3, 16'hffff));
        finish_test("arith");
    endtask

    task automatic check_dependencies();
        for (int d = 1; d <= 4; d++) begin
            drive(enc_i(`OP_ADDIU, 5'd5, 5'd0, 16'(d * 'h111)));
            for (int k = 1; k < d; k++) begin
                drive(enc_i(`OP_ADDIU, 5'd7, 5'd5, 16'(k)));
            end
            drive(enc_r(`FUNCT_ADDU, 5'd6, 5'd5, 5'd5, 5'd0));
        end
        drive(enc_i(`OP_ADDIU, 5'd5, 5'd0, 16'd1));
        drive(enc_i(`OP_ADDIU, 5'd5, 5'd0, 16'd2));
        drive(enc_i(`OP_ADDIU, 5'd5, 5'd0, 16'd3));
        drive(enc_r(`FUNCT_SUBU, 5'd6, 5'd5, 5'd0, 5'd0));  // youngest writer wins
        drive(enc_r(`FUNCT_ADDU, 5'd5, 5'd5, 5'd5, 5'd0));
        drive(enc_r(`FUNCT_ADDU, 5'd5, 5'd5, 5'd5, 5'd0));
        finish_test("dependencies");
    endtask

    task automatic random_stream(input int count);
        logic [31:0]         bits;
        int                  pick;
        mips_pkg::reg_addr_t rd;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        for (int n = 0; n < count; n++) begin
            bits = $random(seed);
            pick = $unsigned($random(seed)) % 26;
            rd   = {2'b00, bits[2:0]};  // few registers, many hazards
            rs   = {2'b00, bits[5:3]};
            rt   = {2'b00, bits[8:6]};
            if (pick < 3) begin
                drive(enc_r(r_functs[pick], rd, 5'd0, rt, bits[13:9]));
            end else if (pick < 18) begin
                drive(enc_r(r_functs[pick], rd, rs, rt, 5'd0));
            end else begin
                drive(enc_i(i_ops[pick - 18], rt, rs, bits[31:16]));
            end
        end
        finish_test("random");
    endtask

    task automatic check_no_write();
        drive(enc_i(`OP_ADDIU, 5'd1, 5'd0, 16'd5));
        drive(enc_r(`FUNCT_MOVN, 5'd2, 5'd1, 5'd1, 5'd0));  // rt just forwarded
        drive(enc_r(`FUNCT_MOVZ, 5'd3, 5'd1, 5'd1, 5'd0));
        drive(enc_i(`OP_ADDIU, 5'd4, 5'd0, 16'd0));
        drive(enc_r(`FUNCT_MOVZ, 5'd3, 5'd1, 5'd4, 5'd0));
        drive(enc_r(`FUNCT_MOVN, 5'd5, 5'd1, 5'd4, 5'd0));
        drive(enc_r(`FUNCT_ADDU, 5'd0, 5'd1, 5'd1, 5'd0));
        drive('0);
        drive(enc_r(6'b011000, 5'd8, 5'd1, 5'd2, 5'd0));    // MULT
        drive(enc_i(6'b100011, 5'd6, 5'd1, 16'h0004));      // LW
        drive(enc_r(`FUNCT_ADDU, 5'd6, 5'd0, 5'd0, 5'd0));
        drive(enc_r(`FUNCT_OR, 5'd7, 5'd0, 5'd1, 5'd0));
        finish_test("no_write");
    endtask

    initial begin
        inst_i  = '0;
        rst_n_i = 1'b0;
        model_reset();
        r_functs = '{`FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA, `FUNCT_SLLV, `FUNCT_SRLV, `FUNCT_SRAV,
                     `FUNCT_ADD, `FUNCT_ADDU, `FUNCT_SUB, `FUNCT_SUBU, `FUNCT_AND, `FUNCT_OR,
                     `FUNCT_XOR, `FUNCT_NOR, `FUNCT_SLT, `FUNCT_SLTU, `FUNCT_MOVN, `FUNCT_MOVZ};
        i_ops = '{`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_ADDI, `OP_ADDIU, `OP_SLTI,
                  `OP_SLTIU};
        @(posedge clk);
        @(negedge clk);
        started = 1'b1;     // write enables cleared by the first reset edge
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
        repeat (8) @(negedge clk);
        check_reset();
        check_logic();
        check_shifts();
        check_arith();
        check_dependencies();
        random_stream(RAND_COUNT);
        check_no_write();
        $display("tests run: %0d, errors: %0d", test_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== logic/ex_stage.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module ex_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mips_pkg::alu_op_e   aluop_i,
    input  mips_pkg::alu_sel_e  alusel_i,
    input  mips_pkg::word_t     reg1_i,
    input  mips_pkg::word_t     reg2_i,
    input  mips_pkg::reg_addr_t wd_i,
    input  logic                wreg_i,
    output mips_pkg::word_t     ex_wdata_o,
    output mips_pkg::reg_addr_t ex_wd_o,
    output logic                ex_wreg_o
);

    mips_pkg::alu_op_e  aluop_q;
    mips_pkg::alu_sel_e alusel_q;
    mips_pkg::word_t    reg1_q;
    mips_pkg::word_t    reg2_q;
    mips_pkg::word_t    logic_res;
    mips_pkg::word_t    shift_res;
    mips_pkg::word_t    arith_res;
    logic [4:0]         sa;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            aluop_q   <= mips_pkg::ALU_NOP;
            alusel_q  <= mips_pkg::SEL_NOP;
            ex_wreg_o <= 1'b0;
        end else begin
            aluop_q   <= aluop_i;
            alusel_q  <= alusel_i;
            ex_wreg_o <= wreg_i;
        end
    end

    always_ff @(posedge clk) begin
        reg1_q  <= reg1_i;
        reg2_q  <= reg2_i;
        ex_wd_o <= wd_i;
    end

    assign sa = reg1_q[4:0];    // only low bits shift

    always_comb begin
        case (aluop_q)
            mips_pkg::ALU_AND: logic_res = reg1_q & reg2_q;
            mips_pkg::ALU_OR:  logic_res = reg1_q | reg2_q;
            mips_pkg::ALU_XOR: logic_res = reg1_q ^ reg2_q;
            mips_pkg::ALU_NOR: logic_res = ~(reg1_q | reg2_q);
            mips_pkg::ALU_LUI: logic_res = {reg2_q[`IMM_HI:`IMM_LO], 16'h0000};
            default:           logic_res = '0;
        endcase
    end

    always_comb begin
        case (aluop_q)
            mips_pkg::ALU_SLL: shift_res = reg2_q << sa;
            mips_pkg::ALU_SRL: shift_res = reg2_q >> sa;
            mips_pkg::ALU_SRA: shift_res = $signed(reg2_q) >>> sa;
            default:           shift_res = '0;
        endcase
    end

    // no overflow trap, add and sub wrap
    always_comb begin
        case (aluop_q)
            mips_pkg::ALU_ADD, mips_pkg::ALU_ADDU: arith_res = reg1_q + reg2_q;
            mips_pkg::ALU_SUB, mips_pkg::ALU_SUBU: arith_res = reg1_q - reg2_q;
            mips_pkg::ALU_SLT:  arith_res = {31'b0, $signed(reg1_q) < $signed(reg2_q)};
            mips_pkg::ALU_SLTU: arith_res = {31'b0, reg1_q < reg2_q};
            default:            arith_res = '0;
        endcase
    end

    always_comb begin
        case (alusel_q)
            mips_pkg::SEL_LOGIC: ex_wdata_o = logic_res;
            mips_pkg::SEL_SHIFT: ex_wdata_o = shift_res;
            mips_pkg::SEL_ARITH: ex_wdata_o = arith_res;
            mips_pkg::SEL_MOVE:  ex_wdata_o = reg1_q;   // condition settled in decode
            default:             ex_wdata_o = '0;
        endcase
    end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module id_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  mips_pkg::inst_t      inst_i,
    input  mips_pkg::word_t      rs_data_i,
    input  mips_pkg::word_t      rt_data_i,
    input  mips_pkg::word_t      ex_wdata_i,
    input  mips_pkg::reg_addr_t  ex_wd_i,
    input  logic                 ex_wreg_i,
    input  mips_pkg::word_t      mem_wdata_i,
    input  mips_pkg::reg_addr_t  mem_wd_i,
    input  logic                 mem_wreg_i,
    output mips_pkg::reg_addr_t  rs_addr_o,
    output mips_pkg::reg_addr_t  rt_addr_o,
    output mips_pkg::alu_op_e    aluop_o,
    output mips_pkg::alu_sel_e   alusel_o,
    output mips_pkg::word_t      reg1_o,
    output mips_pkg::word_t      reg2_o,
    output mips_pkg::reg_addr_t  wd_o,
    output logic                 wreg_o
);

    mips_pkg::inst_t inst_q;
    logic [5:0]      opcode;
    logic [5:0]      funct;
    logic [4:0]      shamt;
    logic            imm_shift;
    mips_pkg::word_t imm;
    logic            rs_read;
    logic            rt_read;
    logic            wr_rd;     // R-type, destination is rd
    logic            move_ok;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_q <= '0;
        end else begin
            inst_q <= inst_i;
        end
    end

    assign opcode    = inst_q[`OPCODE_HI:`OPCODE_LO];
    assign funct     = inst_q[`FUNCT_HI:`FUNCT_LO];
    assign shamt     = inst_q[`SHAMT_HI:`SHAMT_LO];
    assign rs_addr_o = inst_q[`RS_HI:`RS_LO];
    assign rt_addr_o = inst_q[`RT_HI:`RT_LO];
    assign imm_shift = (funct == `FUNCT_SLL) || (funct == `FUNCT_SRL) || (funct == `FUNCT_SRA);

    always_comb begin
        aluop_o = mips_pkg::ALU_NOP;
        rs_read = 1'b1;
        rt_read = 1'b0;
        wr_rd   = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                wr_rd   = 1'b1;
                rs_read = !imm_shift;   // shamt replaces rs
                rt_read = 1'b1;
                if (imm_shift ? (rs_addr_o == '0) : (shamt == '0)) begin
                    case (funct)
                        `FUNCT_AND:  aluop_o = mips_pkg::ALU_AND;
                        `FUNCT_OR:   aluop_o = mips_pkg::ALU_OR;
                        `FUNCT_XOR:  aluop_o = mips_pkg::ALU_XOR;
                        `FUNCT_NOR:  aluop_o = mips_pkg::ALU_NOR;
                        `FUNCT_SLL:  aluop_o = mips_pkg::ALU_SLL;
                        `FUNCT_SRL:  aluop_o = mips_pkg::ALU_SRL;
                        `FUNCT_SRA:  aluop_o = mips_pkg::ALU_SRA;
                        `FUNCT_SLLV: aluop_o = mips_pkg::ALU_SLL;
                        `FUNCT_SRLV: aluop_o = mips_pkg::ALU_SRL;
                        `FUNCT_SRAV: aluop_o = mips_pkg::ALU_SRA;
                        `FUNCT_ADD:  aluop_o = mips_pkg::ALU_ADD;
                        `FUNCT_ADDU: aluop_o = mips_pkg::ALU_ADDU;
                        `FUNCT_SUB:  aluop_o = mips_pkg::ALU_SUB;
                        `FUNCT_SUBU: aluop_o = mips_pkg::ALU_SUBU;
                        `FUNCT_SLT:  aluop_o = mips_pkg::ALU_SLT;
                        `FUNCT_SLTU: aluop_o = mips_pkg::ALU_SLTU;
                        `FUNCT_MOVN: aluop_o = mips_pkg::ALU_MOVN;
                        `FUNCT_MOVZ: aluop_o = mips_pkg::ALU_MOVZ;
                        default:     aluop_o = mips_pkg::ALU_NOP;
                    endcase
                end
            end
            `OP_ANDI:  aluop_o = mips_pkg::ALU_AND;
            `OP_ORI:   aluop_o = mips_pkg::ALU_OR;
            `OP_XORI:  aluop_o = mips_pkg::ALU_XOR;
            `OP_LUI:   aluop_o = mips_pkg::ALU_LUI;
            `OP_ADDI:  aluop_o = mips_pkg::ALU_ADD;
            `OP_ADDIU: aluop_o = mips_pkg::ALU_ADDU;
            `OP_SLTI:  aluop_o = mips_pkg::ALU_SLT;
            `OP_SLTIU: aluop_o = mips_pkg::ALU_SLTU;
            default:   aluop_o = mips_pkg::ALU_NOP;
        endcase
    end

    always_comb begin
        case (aluop_o)
            mips_pkg::ALU_AND, mips_pkg::ALU_OR, mips_pkg::ALU_XOR, mips_pkg::ALU_NOR,
            mips_pkg::ALU_LUI:
                alusel_o = mips_pkg::SEL_LOGIC;
            mips_pkg::ALU_SLL, mips_pkg::ALU_SRL, mips_pkg::ALU_SRA:
                alusel_o = mips_pkg::SEL_SHIFT;
            mips_pkg::ALU_ADD, mips_pkg::ALU_ADDU, mips_pkg::ALU_SUB, mips_pkg::ALU_SUBU,
            mips_pkg::ALU_SLT, mips_pkg::ALU_SLTU:
                alusel_o = mips_pkg::SEL_ARITH;
            mips_pkg::ALU_MOVN, mips_pkg::ALU_MOVZ:
                alusel_o = mips_pkg::SEL_MOVE;
            default:
                alusel_o = mips_pkg::SEL_NOP;
        endcase
    end

    // logic immediates zero-extend, arithmetic ones sign-extend
    always_comb begin
        if (opcode == `OP_SPECIAL) begin
            imm = {27'b0, shamt};
        end else if (alusel_o == mips_pkg::SEL_LOGIC) begin
            imm = {16'b0, inst_q[`IMM_HI:`IMM_LO]};
        end else begin
            imm = {{16{inst_q[`IMM_HI]}}, inst_q[`IMM_HI:`IMM_LO]};
        end
    end

    // youngest writer wins: execute, then memory, then register file
    function automatic mips_pkg::word_t fwd(input mips_pkg::reg_addr_t addr,
                                            input mips_pkg::word_t     rf_data);
        if (ex_wreg_i && (ex_wd_i == addr)) begin
            return ex_wdata_i;
        end else if (mem_wreg_i && (mem_wd_i == addr)) begin
            return mem_wdata_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        if (rs_read) begin
            reg1_o = fwd(rs_addr_o, rs_data_i);
        end else begin
            reg1_o = imm;
        end
        if (rt_read) begin
            reg2_o = fwd(rt_addr_o, rt_data_i);
        end else begin
            reg2_o = imm;
        end
    end

    assign wd_o = wr_rd ? inst_q[`RD_HI:`RD_LO] : inst_q[`RT_HI:`RT_LO];

    always_comb begin
        case (aluop_o)
            mips_pkg::ALU_MOVN: move_ok = (reg2_o != '0);
            mips_pkg::ALU_MOVZ: move_ok = (reg2_o == '0);
            default:            move_ok = 1'b1;
        endcase
    end

    assign wreg_o = (aluop_o != mips_pkg::ALU_NOP) && move_ok && (wd_o != '0);

endmodule

// ==== logic/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// instruction field positions
`define OPCODE_HI   31
`define OPCODE_LO   26
`define RS_HI       25
`define RS_LO       21
`define RT_HI       20
`define RT_LO       16
`define RD_HI       15
`define RD_LO       11
`define SHAMT_HI    10
`define SHAMT_LO    6
`define FUNCT_HI    5
`define FUNCT_LO    0
`define IMM_HI      15
`define IMM_LO      0

`define REG_COUNT   32

// opcodes
`define OP_SPECIAL  6'b000000   // R-type, see funct
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// funct codes under OP_SPECIAL
`define FUNCT_SLL   6'b000000   // shamt form
`define FUNCT_SRL   6'b000010
`define FUNCT_SRA   6'b000011
`define FUNCT_SLLV  6'b000100
`define FUNCT_SRLV  6'b000110
`define FUNCT_SRAV  6'b000111
`define FUNCT_MOVZ  6'b001010
`define FUNCT_MOVN  6'b001011
`define FUNCT_ADD   6'b100000
`define FUNCT_ADDU  6'b100001
`define FUNCT_SUB   6'b100010
`define FUNCT_SUBU  6'b100011
`define FUNCT_AND   6'b100100
`define FUNCT_OR    6'b100101
`define FUNCT_XOR   6'b100110
`define FUNCT_NOR   6'b100111
`define FUNCT_SLT   6'b101010
`define FUNCT_SLTU  6'b101011

`endif

// ==== logic/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mips_pkg::inst_t     inst_i,
    output logic                wb_we_o,
    output mips_pkg::reg_addr_t wb_addr_o,
    output mips_pkg::word_t     wb_data_o
);

    mips_pkg::reg_addr_t rs_addr;
    mips_pkg::reg_addr_t rt_addr;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    mips_pkg::alu_op_e   id_aluop;
    mips_pkg::alu_sel_e  id_alusel;
    mips_pkg::word_t     id_reg1;
    mips_pkg::word_t     id_reg2;
    mips_pkg::reg_addr_t id_wd;
    logic                id_wreg;
    mips_pkg::word_t     ex_wdata;
    mips_pkg::reg_addr_t ex_wd;
    logic                ex_wreg;
    mips_pkg::word_t     mem_wdata;
    mips_pkg::reg_addr_t mem_wd;
    logic                mem_wreg;

    id_stage u_id (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .ex_wdata_i  (ex_wdata),
        .ex_wd_i     (ex_wd),
        .ex_wreg_i   (ex_wreg),
        .mem_wdata_i (mem_wdata),
        .mem_wd_i    (mem_wd),
        .mem_wreg_i  (mem_wreg),
        .rs_addr_o   (rs_addr),
        .rt_addr_o   (rt_addr),
        .aluop_o     (id_aluop),
        .alusel_o    (id_alusel),
        .reg1_o      (id_reg1),
        .reg2_o      (id_reg2),
        .wd_o        (id_wd),
        .wreg_o      (id_wreg)
    );

    regfile u_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .we_i      (mem_wreg),      // written from the mem register
        .waddr_i   (mem_wd),
        .wdata_i   (mem_wdata),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    ex_stage u_ex (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .aluop_i    (id_aluop),
        .alusel_i   (id_alusel),
        .reg1_i     (id_reg1),
        .reg2_i     (id_reg2),
        .wd_i       (id_wd),
        .wreg_i     (id_wreg),
        .ex_wdata_o (ex_wdata),
        .ex_wd_o    (ex_wd),
        .ex_wreg_o  (ex_wreg)
    );

    wb_stage u_wb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_wdata_i  (ex_wdata),
        .ex_wd_i     (ex_wd),
        .ex_wreg_i   (ex_wreg),
        .mem_wdata_o (mem_wdata),
        .mem_wd_o    (mem_wd),
        .mem_wreg_o  (mem_wreg),
        .wb_we_o     (wb_we_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

// ==== logic/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;        // data word
    typedef logic [31:0] inst_t;        // raw instruction
    typedef logic [4:0]  reg_addr_t;    // register index

    // operation class, picks the result path in execute
    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_ARITH = 3'd3,
        SEL_MOVE  = 3'd4
    } alu_sel_e;

    typedef enum logic [4:0] {
        ALU_NOP  = 5'd0,    // also marks an unrecognized instruction
        ALU_AND  = 5'd1,
        ALU_OR   = 5'd2,
        ALU_XOR  = 5'd3,
        ALU_NOR  = 5'd4,
        ALU_LUI  = 5'd5,
        ALU_SLL  = 5'd6,
        ALU_SRL  = 5'd7,
        ALU_SRA  = 5'd8,
        ALU_ADD  = 5'd9,
        ALU_ADDU = 5'd10,
        ALU_SUB  = 5'd11,
        ALU_SUBU = 5'd12,
        ALU_SLT  = 5'd13,
        ALU_SLTU = 5'd14,
        ALU_MOVN = 5'd15,
        ALU_MOVZ = 5'd16
    } alu_op_e;

endpackage

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module regfile (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  mips_pkg::word_t     wdata_i,
    input  mips_pkg::reg_addr_t rs_addr_i,
    input  mips_pkg::reg_addr_t rt_addr_i,
    output mips_pkg::word_t     rs_data_o,
    output mips_pkg::word_t     rt_data_o
);

    mips_pkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is hardwired to zero
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

endmodule

// ==== logic/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mips_pkg::word_t     ex_wdata_i,
    input  mips_pkg::reg_addr_t ex_wd_i,
    input  logic                ex_wreg_i,
    output mips_pkg::word_t     mem_wdata_o,
    output mips_pkg::reg_addr_t mem_wd_o,
    output logic                mem_wreg_o,
    output logic                wb_we_o,
    output mips_pkg::reg_addr_t wb_addr_o,
    output mips_pkg::word_t     wb_data_o
);

    // mem register feeds both the forward path and the regfile write port
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_wreg_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            mem_wreg_o <= ex_wreg_i;
            wb_we_o    <= mem_wreg_o;   // same edge as regfile write
        end
    end

    always_ff @(posedge clk) begin
        mem_wdata_o <= ex_wdata_i;
        mem_wd_o    <= ex_wd_i;
        wb_addr_o   <= mem_wd_o;
        wb_data_o   <= mem_wdata_o;
    end

endmodule

// ==== project.f ====
+incdir+logic
+incdir+dv
logic/mips_pkg.sv
logic/regfile.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/wb_stage.sv
logic/mips_core.sv
dv/tb_mips_core.sv
